//--- vision_pkg.sv
/*
  shared definitions for the orange target tracker
  colour thresholds, pixel channel width, direction encoding
*/

`default_nettype none

package vision_pkg;

  // bits per colour channel
  localparam int pixel_width = 8;

  // orange window in rgb space
  // red must be strong
  localparam logic [pixel_width-1:0] red_min = 8'd200;

  // green in a middle band, too little is red, too much is yellow
  localparam logic [pixel_width-1:0] green_min = 8'd80;
  localparam logic [pixel_width-1:0] green_max = 8'd180;

  // blue kept low to reject pinks and whites
  localparam logic [pixel_width-1:0] blue_max = 8'd60;

  // direction of the target seen in the last frame
  // dir_none whenever no target was detected
  typedef enum logic [1:0] {
    dir_none   = 2'd0,
    dir_left   = 2'd1,
    dir_center = 2'd2,
    dir_right  = 2'd3
  } dir_t;

endpackage

`default_nettype wire

//--- orange_color_detector.sv
/*
  per pixel orange detector
  threshold test on the incoming rgb pixel and recoloured output,
  one register stage
*/

`timescale 1ns/1ps
`default_nettype none

module orange_color_detector import vision_pkg::*; (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic [pixel_width-1:0] red,
  input  wire logic [pixel_width-1:0] green,
  input  wire logic [pixel_width-1:0] blue,
  input  wire logic                   active,
  output logic      [pixel_width-1:0] red_out,
  output logic      [pixel_width-1:0] green_out,
  output logic      [pixel_width-1:0] blue_out,
  output logic                        is_orange
);

  // individual threshold tests
  logic red_ok;
  logic green_ok;
  logic blue_ok;
  logic orange_hit;

  assign red_ok   = (red >= red_min);
  assign green_ok = (green >= green_min) && (green <= green_max);
  assign blue_ok  = (blue <= blue_max);

  // only visible pixels can count as orange
  assign orange_hit = active && red_ok && green_ok && blue_ok;

  // register the flag together with the pixel so both stay aligned
  always_ff @(posedge clk) begin
    if (rst) begin
      is_orange <= 1'b0;
      red_out   <= '0;
      green_out <= '0;
      blue_out  <= '0;
    end else begin
      is_orange <= orange_hit;
      if (!active) begin
        // blanking, monitor expects black
        red_out   <= '0;
        green_out <= '0;
        blue_out  <= '0;
      end else if (orange_hit) begin
        // target pixel goes through untouched
        red_out   <= red;
        green_out <= green;
        blue_out  <= blue;
      end else begin
        // dim the background to half so the target stands out
        red_out   <= red >> 1;
        green_out <= green >> 1;
        blue_out  <= blue >> 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- frame_position_counter.sv
/*
  pixel position tracking
  column counter over active pixels and frame end pulse
  from the vsync rising edge
*/

`timescale 1ns/1ps
`default_nettype none

module frame_position_counter #(
  parameter int h_active = 640
) (
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire logic                        active,
  input  wire logic                        vsync,
  output logic      [$clog2(h_active)-1:0] column,
  output logic                             frame_done
);

  localparam int col_w = $clog2(h_active);
  localparam logic [col_w-1:0] col_last = col_w'(h_active - 1);

  // previous samples for edge detection
  logic active_d;
  logic vsync_d;

  always_ff @(posedge clk) begin
    if (rst) begin
      active_d <= 1'b0;
      vsync_d  <= 1'b0;
    end else begin
      active_d <= active;
      vsync_d  <= vsync;
    end
  end

  // column is registered so it lines up with the detector output
  always_ff @(posedge clk) begin
    if (rst) begin
      column <= '0;
    end else if (active && !active_d) begin
      // first visible pixel of a line
      column <= '0;
    end else if (active && (column != col_last)) begin
      column <= column + 1'b1;
    end
    // otherwise hold, also saturates at the last column
  end

  // single cycle pulse on the first cycle vsync is seen high
  always_ff @(posedge clk) begin
    if (rst) begin
      frame_done <= 1'b0;
    end else begin
      frame_done <= vsync && !vsync_d;
    end
  end

endmodule

`default_nettype wire

//--- direction_classifier.sv
/*
  target direction classifier
  orange pixel counters for the left, centre and right thirds,
  per frame decision on detection and direction
*/

`timescale 1ns/1ps
`default_nettype none

module direction_classifier import vision_pkg::*; #(
  parameter int h_active    = 640,
  parameter int count_width = 17,
  parameter int min_pixels  = 64
) (
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire logic                        is_orange,
  input  wire logic [$clog2(h_active)-1:0] column,
  input  wire logic                        frame_done,
  output dir_t                             direction,
  output logic                             detected
);

  localparam int col_w = $clog2(h_active);
  localparam int sum_w = count_width + 2;

  // third boundaries along the line
  localparam logic [col_w-1:0] bound_left  = col_w'(h_active / 3);
  localparam logic [col_w-1:0] bound_right = col_w'((2 * h_active) / 3);

  localparam logic [sum_w-1:0] min_total = sum_w'(min_pixels);

  logic [count_width-1:0] cnt_left;
  logic [count_width-1:0] cnt_center;
  logic [count_width-1:0] cnt_right;

  logic       in_left;
  logic       in_center;
  logic       in_right;
  logic [sum_w-1:0] total;
  logic       hit_next;
  dir_t       dir_next;

  // sort the current column into one third
  assign in_left   = (column < bound_left);
  assign in_center = !in_left && (column < bound_right);
  assign in_right  = !in_left && !in_center;

  // per third counters, cleared at each frame end
  always_ff @(posedge clk) begin
    if (rst || frame_done) begin
      cnt_left   <= '0;
      cnt_center <= '0;
      cnt_right  <= '0;
    end else if (is_orange) begin
      // saturate instead of wrapping on very large targets
      if (in_left && (cnt_left != '1)) begin
        cnt_left <= cnt_left + 1'b1;
      end
      if (in_center && (cnt_center != '1)) begin
        cnt_center <= cnt_center + 1'b1;
      end
      if (in_right && (cnt_right != '1)) begin
        cnt_right <= cnt_right + 1'b1;
      end
    end
  end

  // frame decision from the running counts
  assign total = sum_w'(cnt_left) + sum_w'(cnt_center) + sum_w'(cnt_right);
  assign hit_next = (total >= min_total);

  always_comb begin
    if (!hit_next) begin
      dir_next = dir_none;
    end else if ((cnt_center >= cnt_left) && (cnt_center >= cnt_right)) begin
      // centre wins every tie
      dir_next = dir_center;
    end else if (cnt_left >= cnt_right) begin
      // then left
      dir_next = dir_left;
    end else begin
      dir_next = dir_right;
    end
  end

  // result held until the next frame end
  always_ff @(posedge clk) begin
    if (rst) begin
      direction <= dir_none;
      detected  <= 1'b0;
    end else if (frame_done) begin
      direction <= dir_next;
      detected  <= hit_next;
    end
  end

endmodule

`default_nettype wire

//--- target_tracker_top.sv
/*
  orange target tracker top level
  colour detector, position counter and direction classifier
*/

`timescale 1ns/1ps
`default_nettype none

module target_tracker_top import vision_pkg::*; #(
  parameter int h_active    = 640,
  parameter int count_width = 17,
  parameter int min_pixels  = 64
) (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic [pixel_width-1:0] red,
  input  wire logic [pixel_width-1:0] green,
  input  wire logic [pixel_width-1:0] blue,
  input  wire logic                   active,
  input  wire logic                   vsync,
  output logic      [pixel_width-1:0] red_out,
  output logic      [pixel_width-1:0] green_out,
  output logic      [pixel_width-1:0] blue_out,
  output logic                        is_orange,
  output dir_t                        direction,
  output logic                        detected
);

  // column of the pixel currently on is_orange
  logic [$clog2(h_active)-1:0] column;
  logic                        frame_done;

  // recolouring and orange flag, one cycle behind the input
  orange_color_detector orange_color_detector_inst (
    .clk       (clk),
    .rst       (rst),
    .red       (red),
    .green     (green),
    .blue      (blue),
    .active    (active),
    .red_out   (red_out),
    .green_out (green_out),
    .blue_out  (blue_out),
    .is_orange (is_orange)
  );

  // runs in parallel on the same raw levels
  frame_position_counter #(
    .h_active (h_active)
  ) frame_position_counter_inst (
    .clk        (clk),
    .rst        (rst),
    .active     (active),
    .vsync      (vsync),
    .column     (column),
    .frame_done (frame_done)
  );

  direction_classifier #(
    .h_active    (h_active),
    .count_width (count_width),
    .min_pixels  (min_pixels)
  ) direction_classifier_inst (
    .clk        (clk),
    .rst        (rst),
    .is_orange  (is_orange),
    .column     (column),
    .frame_done (frame_done),
    .direction  (direction),
    .detected   (detected)
  );

endmodule

`default_nettype wire

//--- target_tracker_asserts.sv
/*
  concurrent checks bound into the tracker top level
  reset value, frame pulse width, direction while nothing is detected
*/

`timescale 1ns/1ps
`default_nettype none

module target_tracker_asserts import vision_pkg::*; (
  input wire logic clk,
  input wire logic rst,
  input wire logic frame_done,
  input wire logic detected,
  input wire dir_t direction
);

  // read back by the testbench at the end of the run
  int fail_count = 0;

  a_reset_detected: assert property (@(posedge clk) rst |=> !detected)
    else begin
      fail_count++;
      $error("detected high after a reset cycle");
    end

  // frame end is a single cycle pulse
  a_frame_pulse: assert property (@(posedge clk) disable iff (rst) frame_done |=> !frame_done)
    else begin
      fail_count++;
      $error("frame_done held for more than one cycle");
    end

  a_dir_none: assert property (@(posedge clk) disable iff (rst)
    !detected |-> (direction == dir_none))
    else begin
      fail_count++;
      $error("direction set while detected is low");
    end

endmodule

bind target_tracker_top target_tracker_asserts target_tracker_asserts_inst (
  .clk        (clk),
  .rst        (rst),
  .frame_done (frame_done),
  .detected   (detected),
  .direction  (direction)
);

`default_nettype wire

//--- tb_target_tracker.sv
/*
  testbench for the orange target tracker
  frames read from the trace, per pixel output checks,
  frame result checks and a watchdog
*/

`timescale 1ns/1ps
`default_nettype none

module tb_target_tracker import vision_pkg::*; ();

  // small frame so every third is only four columns wide
  localparam int h_active   = 12;
  localparam int min_pixels = 3;

  logic                   clk = 1'b0;
  logic                   rst;
  logic [pixel_width-1:0] red;
  logic [pixel_width-1:0] green;
  logic [pixel_width-1:0] blue;
  logic                   active;
  logic                   vsync;
  logic [pixel_width-1:0] red_out;
  logic [pixel_width-1:0] green_out;
  logic [pixel_width-1:0] blue_out;
  logic                   is_orange;
  dir_t                   direction;
  logic                   detected;

  // expected outputs for the pixel driven one cycle earlier
  // start out at the reset state
  logic [pixel_width-1:0] exp_r = '0;
  logic [pixel_width-1:0] exp_g = '0;
  logic [pixel_width-1:0] exp_b = '0;
  logic                   exp_orange = 1'b0;

  logic [31:0] lfsr = 32'h272bad28;
  int          trace_q[$];
  int          errors = 0;
  int          checks = 0;
  int          limit_cycles = 0;

  target_tracker_top #(
    .h_active   (h_active),
    .min_pixels (min_pixels)
  ) target_tracker_top_inst (.*);

  always #10 clk = ~clk;

  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit taken
  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v = '0;
    repeat (n) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[6:0], lfsr[0]};
    end
    return v;
  endfunction

  // reference decision worked out from the rectangle alone
  function automatic int thirds_direction(input int c0, input int c1,
                                          input int r0, input int r1);
    int rows = (r1 >= r0) ? r1 - r0 + 1 : 0;
    int left = 0;
    int center = 0;
    int right = 0;
    for (int c = c0; c <= c1; c++) begin
      if (c < h_active / 3) begin
        left += rows;
      end else if (c < 2 * h_active / 3) begin
        center += rows;
      end else begin
        right += rows;
      end
    end
    if (left + center + right < min_pixels) begin
      return int'(dir_none);
    end
    // ties go to centre, then left
    if (center >= left && center >= right) begin
      return int'(dir_center);
    end
    if (left >= right) begin
      return int'(dir_left);
    end
    return int'(dir_right);
  endfunction

  task automatic compare(input string what, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // one pixel clock that checks the outputs of the previous pixel
  task automatic drive_cycle(input logic [7:0] r, input logic [7:0] g, input logic [7:0] b,
                             input logic act, input logic vs, input logic in_rect);
    @(posedge clk);
    red    <= r;
    green  <= g;
    blue   <= b;
    active <= act;
    vsync  <= vs;
    @(negedge clk);
    compare("red_out", int'(red_out), int'(exp_r));
    compare("green_out", int'(green_out), int'(exp_g));
    compare("blue_out", int'(blue_out), int'(exp_b));
    compare("is_orange", int'(is_orange), int'(exp_orange));
    exp_orange = in_rect;
    // blanking is black, background halved, target unchanged
    exp_r = !act ? 8'd0 : (in_rect ? r : r >> 1);
    exp_g = !act ? 8'd0 : (in_rect ? g : g >> 1);
    exp_b = !act ? 8'd0 : (in_rect ? b : b >> 1);
  endtask

  initial begin
    int    fd;
    int    total;
    int    v[7];
    int    fr[7];
    int    row;
    int    col;
    int    dir_calc;
    string line;
    rst    = 1'b1;
    red    = '0;
    green  = '0;
    blue   = '0;
    active = 1'b0;
    vsync  = 1'b0;
    total  = 0;
    fd = $fopen("target_trace.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open target_trace.txt for reading");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line[0] != "#" &&
            $sscanf(line, "%d %d %d %d %d %d %d",
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6]) == 7) begin
          foreach (v[k]) begin
            trace_q.push_back(v[k]);
          end
          total += v[0] * (h_active + 2) + 20;
        end
      end
      $fclose(fd);
    end
    // reset and margin on top of the frame lengths
    limit_cycles = total + 110;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    compare("detected after reset", int'(detected), 0);
    compare("direction after reset", int'(direction), int'(dir_none));
    compare("pixel after reset", int'({red_out, green_out, blue_out}), 0);
    for (int f = 0; f < trace_q.size() / 7; f++) begin
      // lines, first col, last col, first line, last line, direction, detected
      foreach (fr[k]) begin
        fr[k] = trace_q[7 * f + k];
      end
      for (row = 0; row < fr[0]; row++) begin
        for (col = 0; col < h_active + 2; col++) begin
          if (col < h_active && col >= fr[1] && col <= fr[2] && row >= fr[3] && row <= fr[4]) begin
            drive_cycle(8'd230, 8'd120, 8'd20, 1'b1, 1'b0, 1'b1);
          end else begin
            // background red stays below 128
            drive_cycle(rand_bits(7), rand_bits(8), rand_bits(8), col < h_active, 1'b0, 1'b0);
          end
        end
      end
      // result shows two cycles after vsync is first sampled high
      repeat (3) drive_cycle(8'd0, 8'd0, 8'd0, 1'b0, 1'b1, 1'b0);
      dir_calc = thirds_direction(fr[1], fr[2], fr[3], fr[4]);
      if (dir_calc != fr[5] || (dir_calc != 0) != (fr[6] != 0)) begin
        errors++;
        $display("FAIL %0t: trace frame %0d disagrees with the thirds rule", $time, f);
      end
      compare("direction", int'(direction), fr[5]);
      compare("detected", int'(detected), fr[6]);
      repeat (4) drive_cycle(8'd0, 8'd0, 8'd0, 1'b0, 1'b0, 1'b0);
    end
    errors += target_tracker_top_inst.target_tracker_asserts_inst.fail_count;
    $display("errors: %0d, checks: %0d, frames: %0d", errors, checks, trace_q.size() / 7);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // limit comes from the trace, so wait until it is known
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, frames did not complete", limit_cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- target_trace.txt
# one frame per line: lines, first column, last column, first line, last line,
# expected direction (0 none, 1 left, 2 centre, 3 right), expected detected
6 0 2 1 3 1 1
4 9 11 0 1 3 1
5 5 6 2 2 0 0
5 3 4 0 2 2 1
4 6 9 1 2 2 1
3 2 9 0 0 2 1
6 1 0 0 0 0 0
8 5 11 0 7 3 1
4 0 11 3 3 2 1
3 0 0 0 2 1 1
3 11 11 0 1 0 0

//--- filelist.f
vision_pkg.sv
orange_color_detector.sv
frame_position_counter.sv
direction_classifier.sv
target_tracker_top.sv
target_tracker_asserts.sv
tb_target_tracker.sv

//--- Makefile
# Verilator build and run of the orange target tracker testbench
TOP := tb_target_tracker

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -o $(TOP)

# fails unless the pass line shows up in the simulation output
run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
